//--- logic/vcfg_settings.svh
// vector configuration unit settings
// vector register length and scalar register width shared by
// the type package and the execute stage

`ifndef VCFG_SETTINGS_SVH
`define VCFG_SETTINGS_SVH

// vector register length in bits
`define VCFG_VLEN 128

// scalar register width, also the width of every csr word
`define VCFG_XLEN 32

// vector register length in bytes, read back through vlenb
`define VCFG_VLENB (`VCFG_VLEN / 8)

`endif

//--- logic/vcfg_types_pkg.sv
// vector configuration types
// csr word, element width and group multiplier encodings,
// the vtype register layout and the vl count type

`include "vcfg_settings.svh"

package vcfg_types_pkg;

    // one csr word, as wide as a scalar register
    typedef logic [`VCFG_XLEN-1:0] csr_word_t;

    // selected element width, vsew field of vtype
    // codes 3 to 7 are reserved here, SEW64 is not supported
    typedef enum logic [2:0] {
        SEW8  = 3'd0,
        SEW16 = 3'd1,
        SEW32 = 3'd2
    } vsew_e;

    // register group multiplier, vlmul field of vtype
    typedef enum logic [2:0] {
        LMUL1       = 3'd0,
        LMUL2       = 3'd1,
        LMUL4       = 3'd2,
        LMUL8       = 3'd3,
        LMUL_RSVD   = 3'd4,
        LMUL_EIGHTH = 3'd5,
        LMUL_FOURTH = 3'd6,
        LMUL_HALF   = 3'd7
    } vlmul_e;

    // vtype as laid out in the csr, vill in the msb
    typedef struct packed {
        logic         vill;
        logic [22:0]  reserved;
        logic         vma;
        logic         vta;
        vsew_e        vsew;
        vlmul_e       vlmul;
    } vtype_t;

    // vtype after reset or after an unsupported vset
    localparam vtype_t VTYPE_ILL = vtype_t'({1'b1, 31'b0});

    // vl count, holds vlmax at sew8 and lmul8 (128 elements)
    localparam int VL_W = $clog2(`VCFG_VLEN) + 1;
    typedef logic [VL_W-1:0] vl_t;

endpackage

//--- logic/vcfg_op_pkg.sv
// vector configuration operations
// major opcodes seen by decode, the decoded operation passed
// to execute and the addresses of the vector csrs

package vcfg_op_pkg;

    // major opcode field, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OPV    = 7'b1010111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 values used inside those opcodes
    localparam logic [2:0] F3_VSET  = 3'b111;
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;

    // decoded operation handed to execute
    typedef enum logic [2:0] {
        OP_NONE,
        OP_VSETVLI,
        OP_VSETIVLI,
        OP_VSETVL,
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC,
        OP_ILLEGAL
    } vcfg_op_e;

    // vector csr addresses handled by this unit
    // vxsat, vxrm and vcsr are not implemented
    typedef enum logic [11:0] {
        VSTART = 12'h008,
        VL     = 12'hC20,
        VTYPE  = 12'hC21,
        VLENB  = 12'hC22
    } vcsr_addr_e;

    // funct7 of vsetvl, instr[31:25]
    localparam logic [6:0] F7_VSETVL = 7'b1000000;

endpackage

//--- logic/vcfg_req_if.sv
// decoded request bus
// carries one registered instruction from decode into the
// execute stage, valid for a single cycle

`timescale 1ns/10ps

interface vcfg_req_if;

    logic                       valid;
    vcfg_op_pkg::vcfg_op_e      op;
    // application vector length for the vset forms
    vcfg_types_pkg::csr_word_t  avl;
    vcfg_types_pkg::vtype_t     new_vtype;
    // raw csr field, may hold an address this unit does not know
    logic [11:0]                csr_addr;
    // rs1 value, or uimm for the immediate form
    vcfg_types_pkg::csr_word_t  wdata;
    logic [4:0]                 rd_addr;
    // rs1 field was x0
    logic                       rs1_zero;

    modport dec (
        output valid, op, avl, new_vtype, csr_addr, wdata, rd_addr, rs1_zero
    );

    modport exe (
        input valid, op, avl, new_vtype, csr_addr, wdata, rd_addr, rs1_zero
    );

endinterface

//--- logic/vcfg_wb_if.sv
// raw writeback bus
// unregistered result of the execute stage, picked up by the
// result stage on the next clock edge

`timescale 1ns/10ps

interface vcfg_wb_if;

    logic                       valid;
    logic [4:0]                 rd_addr;
    vcfg_types_pkg::csr_word_t  value;
    // instruction was rejected, value is meaningless
    logic                       illegal;

    modport exe (output valid, rd_addr, value, illegal);

    modport res (input valid, rd_addr, value, illegal);

endinterface

//--- logic/vcfg_decode.sv
// vector configuration decode
// classifies one instruction word into a vset or a vector csr
// access, extracts avl, vtype and csr fields and registers them

`timescale 1ns/10ps

module vcfg_decode (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      instr_valid,
    input  logic [31:0]               instr,
    input  vcfg_types_pkg::csr_word_t rs1_value,
    input  vcfg_types_pkg::csr_word_t rs2_value,
    vcfg_req_if.dec                   req
);

    // instruction fields
    logic [6:0] opcode;
    logic [4:0] rd;
    logic [2:0] funct3;
    logic [4:0] rs1;

    // decoded values before the register
    vcfg_op_pkg::vcfg_op_e      op_d;
    vcfg_types_pkg::csr_word_t  avl_d;
    vcfg_types_pkg::vtype_t     vtype_d;
    vcfg_types_pkg::csr_word_t  wdata_d;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];

    always_comb begin
        op_d    = vcfg_op_pkg::OP_ILLEGAL;
        avl_d   = rs1_value;
        wdata_d = rs1_value;
        // zimm of vsetvli, 11 bits
        vtype_d = vcfg_types_pkg::vtype_t'({21'b0, instr[30:20]});

        case (opcode)
            vcfg_op_pkg::OPC_OPV: begin
                if (funct3 == vcfg_op_pkg::F3_VSET) begin
                    if (!instr[31]) begin
                        op_d = vcfg_op_pkg::OP_VSETVLI;
                    end else if (instr[30]) begin
                        // vsetivli, avl is uimm5 in the rs1 slot
                        op_d    = vcfg_op_pkg::OP_VSETIVLI;
                        avl_d   = vcfg_types_pkg::csr_word_t'(rs1);
                        wdata_d = vcfg_types_pkg::csr_word_t'(rs1);
                        vtype_d = vcfg_types_pkg::vtype_t'({22'b0, instr[29:20]});
                    end else if (instr[31:25] == vcfg_op_pkg::F7_VSETVL) begin
                        op_d    = vcfg_op_pkg::OP_VSETVL;
                        vtype_d = vcfg_types_pkg::vtype_t'(rs2_value);
                    end
                end
            end
            vcfg_op_pkg::OPC_SYSTEM: begin
                // register forms only, immediate csr forms stay illegal
                case (funct3)
                    vcfg_op_pkg::F3_CSRRW: op_d = vcfg_op_pkg::OP_CSRRW;
                    vcfg_op_pkg::F3_CSRRS: op_d = vcfg_op_pkg::OP_CSRRS;
                    vcfg_op_pkg::F3_CSRRC: op_d = vcfg_op_pkg::OP_CSRRC;
                    default:               op_d = vcfg_op_pkg::OP_ILLEGAL;
                endcase
            end
            default: op_d = vcfg_op_pkg::OP_ILLEGAL;
        endcase
    end

    // strobe and operation
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req.valid <= 1'b0;
            req.op    <= vcfg_op_pkg::OP_NONE;
        end else begin
            req.valid <= instr_valid;
            if (instr_valid) begin
                req.op <= op_d;
            end
        end
    end

    // payload fields, only meaningful while valid is high
    always_ff @(posedge CLK) begin
        if (instr_valid) begin
            req.avl       <= avl_d;
            req.new_vtype <= vtype_d;
            req.csr_addr  <= instr[31:20];
            req.wdata     <= wdata_d;
            req.rd_addr   <= rd;
            req.rs1_zero  <= (rs1 == 5'd0);
        end
    end

endmodule

//--- logic/vector_csr_file.sv
// vector csr file, the execute stage
// holds vstart, vl and vtype, computes vlmax and performs the
// vset instructions and the zicsr accesses in a single cycle

`timescale 1ns/10ps

`include "vcfg_settings.svh"

module vector_csr_file (
    input  logic                          CLK,
    input  logic                          nRST,
    vcfg_req_if.exe                       req,
    vcfg_wb_if.exe                        wb,
    output vcfg_types_pkg::vl_t           vl,
    output vcfg_types_pkg::vtype_t        vtype,
    output vcfg_types_pkg::vl_t           vstart
);

    vcfg_types_pkg::vl_t        vl_next;
    vcfg_types_pkg::vtype_t     vtype_next;
    vcfg_types_pkg::vl_t        vstart_next;

    // vlmax of the requested and of the committed vtype
    vcfg_types_pkg::vl_t        new_vlmax;
    vcfg_types_pkg::vl_t        cur_vlmax;

    vcfg_types_pkg::csr_word_t  csr_old;
    vcfg_types_pkg::csr_word_t  result;
    logic                       csr_wr;
    logic                       avl_x0;
    logic                       bad;

    // vlenb >> sew, then scaled by lmul
    function automatic vcfg_types_pkg::vl_t vlmax_of(input vcfg_types_pkg::vtype_t t);
        vcfg_types_pkg::vl_t base;
        base = vcfg_types_pkg::vl_t'(`VCFG_VLENB);
        case (t.vsew)
            vcfg_types_pkg::SEW8:  base = base;
            vcfg_types_pkg::SEW16: base = base >> 1;
            vcfg_types_pkg::SEW32: base = base >> 2;
            default:               base = '0;
        endcase
        case (t.vlmul)
            vcfg_types_pkg::LMUL1:       return base;
            vcfg_types_pkg::LMUL2:       return base << 1;
            vcfg_types_pkg::LMUL4:       return base << 2;
            vcfg_types_pkg::LMUL8:       return base << 3;
            vcfg_types_pkg::LMUL_HALF:   return base >> 1;
            vcfg_types_pkg::LMUL_FOURTH: return base >> 2;
            vcfg_types_pkg::LMUL_EIGHTH: return base >> 3;
            default:                     return '0;
        endcase
    endfunction

    // reserved sew or lmul, or any agnostic policy bit
    function automatic logic vtype_bad(input vcfg_types_pkg::vtype_t t);
        logic sew_ok;
        sew_ok = (t.vsew == vcfg_types_pkg::SEW8) || (t.vsew == vcfg_types_pkg::SEW16) ||
                 (t.vsew == vcfg_types_pkg::SEW32);
        return !sew_ok || (t.vlmul == vcfg_types_pkg::LMUL_RSVD) || t.vta || t.vma;
    endfunction

    assign new_vlmax = vlmax_of(req.new_vtype);
    assign cur_vlmax = vlmax_of(vtype);

    // x0 avl rules apply to the register forms only
    assign avl_x0 = req.rs1_zero && (req.op != vcfg_op_pkg::OP_VSETIVLI);
    // csrrw always writes, set and clear only with a nonzero rs1
    assign csr_wr = (req.op == vcfg_op_pkg::OP_CSRRW) || !req.rs1_zero;

    // old value of the addressed csr
    always_comb begin
        case (req.csr_addr)
            vcfg_op_pkg::VSTART: csr_old = vcfg_types_pkg::csr_word_t'(vstart);
            vcfg_op_pkg::VL:     csr_old = vcfg_types_pkg::csr_word_t'(vl);
            vcfg_op_pkg::VTYPE:  csr_old = vcfg_types_pkg::csr_word_t'(vtype);
            vcfg_op_pkg::VLENB:  csr_old = vcfg_types_pkg::csr_word_t'(`VCFG_VLENB);
            default:             csr_old = '0;
        endcase
    end

    always_comb begin
        vl_next     = vl;
        vtype_next  = vtype;
        vstart_next = vstart;
        result      = '0;
        bad         = 1'b0;

        if (req.valid) begin
            case (req.op)
                vcfg_op_pkg::OP_VSETVLI, vcfg_op_pkg::OP_VSETIVLI,
                vcfg_op_pkg::OP_VSETVL: begin
                    vstart_next = '0;
                    if (vtype_bad(req.new_vtype)) begin
                        vtype_next = vcfg_types_pkg::VTYPE_ILL;
                        vl_next    = '0;
                    end else begin
                        vtype_next       = vcfg_types_pkg::vtype_t'('0);
                        vtype_next.vsew  = req.new_vtype.vsew;
                        vtype_next.vlmul = req.new_vtype.vlmul;
                        if (avl_x0 && (req.rd_addr != 5'd0)) begin
                            vl_next = new_vlmax;
                        end else if (avl_x0) begin
                            // keep vl, clipped if the new group is smaller
                            vl_next = (vl > new_vlmax) ? new_vlmax : vl;
                        end else if (req.avl < vcfg_types_pkg::csr_word_t'(new_vlmax)) begin
                            vl_next = vcfg_types_pkg::vl_t'(req.avl);
                        end else begin
                            vl_next = new_vlmax;
                        end
                    end
                    result = vcfg_types_pkg::csr_word_t'(vl_next);
                end
                vcfg_op_pkg::OP_CSRRW, vcfg_op_pkg::OP_CSRRS,
                vcfg_op_pkg::OP_CSRRC: begin
                    result = csr_old;
                    case (req.csr_addr)
                        vcfg_op_pkg::VSTART: begin
                            if (req.op == vcfg_op_pkg::OP_CSRRW) begin
                                vstart_next = vcfg_types_pkg::vl_t'(req.wdata);
                            end else if (req.op == vcfg_op_pkg::OP_CSRRS) begin
                                vstart_next = vstart | vcfg_types_pkg::vl_t'(req.wdata);
                            end else begin
                                vstart_next = vstart & ~vcfg_types_pkg::vl_t'(req.wdata);
                            end
                            if (!csr_wr) begin
                                vstart_next = vstart;
                            end
                        end
                        // read only from the csr side
                        vcfg_op_pkg::VL, vcfg_op_pkg::VTYPE,
                        vcfg_op_pkg::VLENB: bad = csr_wr;
                        default:            bad = 1'b1;
                    endcase
                end
                vcfg_op_pkg::OP_ILLEGAL: bad = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vl     <= '0;
            vtype  <= vcfg_types_pkg::VTYPE_ILL;
            vstart <= '0;
        end else begin
            // an illegal access leaves all state untouched
            if (!bad) begin
                vl     <= vl_next;
                vtype  <= vtype_next;
                vstart <= vstart_next;
            end
        end
    end

    // raw writeback, registered by the result stage
    assign wb.valid   = req.valid && (req.op != vcfg_op_pkg::OP_NONE);
    assign wb.rd_addr = req.rd_addr;
    assign wb.value   = bad ? '0 : result;
    assign wb.illegal = bad;

    // committed vl always fits the committed vtype
    a_vl_within_vlmax: assert property (@(posedge CLK) disable iff (!nRST)
        vl <= cur_vlmax);

    // an unsupported vtype holds no elements
    a_vill_zero_vl: assert property (@(posedge CLK) disable iff (!nRST)
        vtype.vill |-> (vl == '0));

endmodule

//--- logic/vcfg_result.sv
// vector configuration result stage
// registers the writeback from execute, drops writes to x0
// and raises the illegal-instruction strobe

`timescale 1ns/10ps

module vcfg_result (
    input  logic                      CLK,
    input  logic                      nRST,
    vcfg_wb_if.res                    wb,
    output logic                      rd_valid,
    output logic [4:0]                rd_addr,
    output vcfg_types_pkg::csr_word_t rd_value,
    output logic                      illegal
);

    // x0 is never written
    logic rd_write;

    assign rd_write = wb.valid && !wb.illegal && (wb.rd_addr != 5'd0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            rd_valid <= rd_write;
            illegal  <= wb.valid && wb.illegal;
        end
    end

    // destination and data follow the strobe
    always_ff @(posedge CLK) begin
        if (wb.valid) begin
            rd_addr  <= wb.rd_addr;
            rd_value <= wb.value;
        end
    end

    // a rejected instruction carries no data
    a_reject_no_value: assert property (@(posedge CLK) disable iff (!nRST)
        illegal |-> (rd_value == '0));

endmodule

//--- logic/vcfg_unit.sv
// vector configuration unit top level
// decode, execute and result stages for vset and vector csr
// instructions, one instruction per cycle, no back-pressure

`timescale 1ns/10ps

module vcfg_unit (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      instr_valid,
    input  logic [31:0]               instr,
    input  vcfg_types_pkg::csr_word_t rs1_value,
    input  vcfg_types_pkg::csr_word_t rs2_value,
    output logic                      rd_valid,
    output logic [4:0]                rd_addr,
    output vcfg_types_pkg::csr_word_t rd_value,
    output logic                      illegal,
    output vcfg_types_pkg::vl_t       vl,
    output vcfg_types_pkg::vtype_t    vtype,
    output vcfg_types_pkg::vl_t       vstart
);

    // decode to execute, then execute to result
    vcfg_req_if req_bus ();
    vcfg_wb_if  wb_bus ();

    vcfg_decode u_decode (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .req         (req_bus.dec)
    );

    vector_csr_file u_csr_file (
        .CLK    (CLK),
        .nRST   (nRST),
        .req    (req_bus.exe),
        .wb     (wb_bus.exe),
        .vl     (vl),
        .vtype  (vtype),
        .vstart (vstart)
    );

    vcfg_result u_result (
        .CLK      (CLK),
        .nRST     (nRST),
        .wb       (wb_bus.res),
        .rd_valid (rd_valid),
        .rd_addr  (rd_addr),
        .rd_value (rd_value),
        .illegal  (illegal)
    );

endmodule

//--- verif/vcfg_unit_tb.sv
// vector configuration unit testbench
// runs a table of vset and vector csr instructions, then random
// vsetvli instructions against a reference model of the vl rules

`timescale 1ns/10ps

`include "vcfg_settings.svh"

module vcfg_unit_tb;

    localparam int N_ROWS = 32;
    localparam int N_RAND = 40;
    // two cycles per instruction plus margin for reset
    localparam int TIMEOUT_CYCLES = (N_ROWS + N_RAND) * 2 + 50;
    localparam logic [31:0] VT_ILL = 32'h8000_0000;

    // one stimulus row with its expected response
    typedef struct packed {
        logic [31:0]               instr;
        vcfg_types_pkg::csr_word_t rs1v;
        vcfg_types_pkg::csr_word_t rs2v;
        logic                      exp_rdv;
        vcfg_types_pkg::csr_word_t exp_val;
        logic                      exp_ill;
        vcfg_types_pkg::vl_t       exp_vl;
        vcfg_types_pkg::vtype_t    exp_vtype;
        vcfg_types_pkg::vl_t       exp_vstart;
        // issue together with the next row on consecutive cycles
        logic                      chain;
    } row_t;

    logic                      CLK;
    logic                      nRST;
    logic                      instr_valid;
    logic [31:0]               instr;
    vcfg_types_pkg::csr_word_t rs1_value;
    vcfg_types_pkg::csr_word_t rs2_value;
    logic                      rd_valid;
    logic [4:0]                rd_addr;
    vcfg_types_pkg::csr_word_t rd_value;
    logic                      illegal;
    vcfg_types_pkg::vl_t       vl;
    vcfg_types_pkg::vtype_t    vtype;
    vcfg_types_pkg::vl_t       vstart;

    row_t        rows [N_ROWS];
    int          n_rows;
    logic [15:0] lfsr_state;

    vcfg_unit uut (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .rd_valid    (rd_valid),
        .rd_addr     (rd_addr),
        .rd_value    (rd_value),
        .illegal     (illegal),
        .vl          (vl),
        .vtype       (vtype),
        .vstart      (vstart)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // ends a hung run
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

    // 16-bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // vtype immediate, vma and vta left at 0
    function automatic logic [10:0] vt(input logic [2:0] sew, input logic [2:0] lmul);
        return {5'b0, sew, lmul};
    endfunction

    function automatic logic [31:0] enc_vli(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [10:0] zimm);
        return {1'b0, zimm, rs1, 3'b111, rd, 7'b1010111};
    endfunction

    function automatic logic [31:0] enc_ivli(input logic [4:0] rd, input logic [4:0] uimm,
                                             input logic [10:0] zimm);
        return {2'b11, zimm[9:0], uimm, 3'b111, rd, 7'b1010111};
    endfunction

    function automatic logic [31:0] enc_vl(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {7'b1000000, rs2, rs1, 3'b111, rd, 7'b1010111};
    endfunction

    function automatic logic [31:0] enc_csr(input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [11:0] csr);
        return {csr, rs1, f3, rd, 7'b1110011};
    endfunction

    // element count for vlen, sew and lmul, lmul held in eighths
    function automatic int ref_vlmax(input logic [2:0] sew, input logic [2:0] lmul);
        int lmul_x8;
        case (lmul)
            3'd0:    lmul_x8 = 8;
            3'd1:    lmul_x8 = 16;
            3'd2:    lmul_x8 = 32;
            3'd3:    lmul_x8 = 64;
            3'd5:    lmul_x8 = 1;
            3'd6:    lmul_x8 = 2;
            3'd7:    lmul_x8 = 4;
            default: lmul_x8 = 0;
        endcase
        return (`VCFG_VLEN * lmul_x8) / ((8 << sew) * 8);
    endfunction

    // expected response of vsetvli with a nonzero rs1 and rd
    function automatic row_t ref_vsetvli(input logic [31:0] word, input logic [31:0] avl);
        row_t r;
        int   vmax;
        logic legal;
        r         = '0;
        r.instr   = word;
        r.rs1v    = avl;
        r.exp_rdv = 1'b1;
        legal     = (word[25:23] <= 3'd2) && (word[22:20] != 3'd4) && !word[26] && !word[27];
        vmax      = ref_vlmax(word[25:23], word[22:20]);
        if (!legal) begin
            r.exp_vtype = VT_ILL;
        end else begin
            r.exp_vtype = vcfg_types_pkg::vtype_t'({26'b0, word[25:20]});
            r.exp_val   = (avl < vmax) ? avl : vmax;
            r.exp_vl    = vcfg_types_pkg::vl_t'(r.exp_val);
        end
        return r;
    endfunction

    task automatic add_row(input logic [31:0] word, input int rs1v, input int rs2v,
                           input logic rdv, input int val, input logic ill,
                           input int exp_vl, input logic [31:0] exp_vtype,
                           input int exp_vstart, input logic chain);
        row_t r;
        r.instr      = word;
        r.rs1v       = rs1v;
        r.rs2v       = rs2v;
        r.exp_rdv    = rdv;
        r.exp_val    = val;
        r.exp_ill    = ill;
        r.exp_vl     = vcfg_types_pkg::vl_t'(exp_vl);
        r.exp_vtype  = vcfg_types_pkg::vtype_t'(exp_vtype);
        r.exp_vstart = vcfg_types_pkg::vl_t'(exp_vstart);
        r.chain      = chain;
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic check_word(input string name, input vcfg_types_pkg::csr_word_t exp,
                              input vcfg_types_pkg::csr_word_t got);
        if (got !== exp) begin
            $display("ERR %0t ns %s expected %h seen %h", $time, name, exp, got);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_vtype(input string name, input vcfg_types_pkg::vtype_t exp,
                               input vcfg_types_pkg::vtype_t got);
        if (got !== exp) begin
            $display("ERR %0t ns %s expected %h seen %h", $time, name, exp, got);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_vl(input string name, input vcfg_types_pkg::vl_t exp,
                            input vcfg_types_pkg::vl_t got);
        if (got !== exp) begin
            $display("ERR %0t ns %s expected %0d seen %0d", $time, name, exp, got);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERR %0t ns %s expected %b seen %b", $time, name, exp, got);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic apply_instr(input row_t r);
        instr_valid = 1'b1;
        instr       = r.instr;
        rs1_value   = r.rs1v;
        rs2_value   = r.rs2v;
    endtask

    task automatic drive_idle();
        instr_valid = 1'b0;
        instr       = '0;
        rs1_value   = '0;
        rs2_value   = '0;
    endtask

    // value and destination matter only for a real writeback
    task automatic check_response(input row_t r);
        check_flag("rd_valid", r.exp_rdv, rd_valid);
        check_flag("illegal", r.exp_ill, illegal);
        if (r.exp_rdv) begin
            check_word("rd_value", r.exp_val, rd_value);
            check_word("rd_addr", vcfg_types_pkg::csr_word_t'(r.instr[11:7]),
                       vcfg_types_pkg::csr_word_t'(rd_addr));
        end
        check_vl("vl", r.exp_vl, vl);
        check_vtype("vtype", r.exp_vtype, vtype);
        check_vl("vstart", r.exp_vstart, vstart);
    endtask

    // called at a falling edge, returns at a falling edge
    task automatic run_single(input row_t r);
        apply_instr(r);
        @(negedge CLK);
        drive_idle();
        @(negedge CLK);
        check_response(r);
    endtask

    // back to back, the responses arrive on consecutive cycles
    task automatic run_pair(input row_t a, input row_t b);
        apply_instr(a);
        @(negedge CLK);
        apply_instr(b);
        @(negedge CLK);
        drive_idle();
        check_response(a);
        @(negedge CLK);
        check_response(b);
    endtask

    task automatic fill_table();
        n_rows = 0;
        // reset state seen through csr reads
        add_row(enc_csr(3'b010, 1, 0, vcfg_op_pkg::VTYPE), 0, 0, 1, VT_ILL, 0, 0, VT_ILL, 0, 0);
        add_row(enc_csr(3'b010, 1, 0, vcfg_op_pkg::VL), 0, 0, 1, 0, 0, 0, VT_ILL, 0, 0);
        // vl = min(avl, vlmax) over sew and lmul
        add_row(enc_vli(2, 5, vt(0, 0)), 10, 0, 1, 10, 0, 10, vt(0, 0), 0, 0);
        add_row(enc_vli(2, 5, vt(1, 1)), 100, 0, 1, 16, 0, 16, vt(1, 1), 0, 0);
        add_row(enc_vli(2, 5, vt(2, 3)), 40, 0, 1, 32, 0, 32, vt(2, 3), 0, 0);
        add_row(enc_vli(2, 5, vt(0, 5)), 7, 0, 1, 2, 0, 2, vt(0, 5), 0, 0);
        add_row(enc_vli(2, 5, vt(1, 7)), 3, 0, 1, 3, 0, 3, vt(1, 7), 0, 0);
        add_row(enc_vli(2, 5, vt(2, 6)), 5, 0, 1, 1, 0, 1, vt(2, 6), 0, 0);
        add_row(enc_ivli(3, 20, vt(0, 1)), 0, 0, 1, 20, 0, 20, vt(0, 1), 0, 0);
        add_row(enc_ivli(3, 31, vt(0, 3)), 0, 0, 1, 31, 0, 31, vt(0, 3), 0, 0);
        // uimm 0 gives vl 0, no keep rule for the immediate form
        add_row(enc_ivli(3, 0, vt(1, 0)), 0, 0, 1, 0, 0, 0, vt(1, 0), 0, 0);
        // rs1 x0 with rd not x0 takes vlmax
        add_row(enc_vli(4, 0, vt(0, 2)), 5, 0, 1, 64, 0, 64, vt(0, 2), 0, 0);
        // rs1 x0 and rd x0 keeps vl, no writeback
        add_row(enc_vli(0, 0, vt(0, 3)), 5, 0, 0, 0, 0, 64, vt(0, 3), 0, 0);
        // unsupported vtype: sew64, reserved lmul, vta set
        add_row(enc_vli(2, 5, vt(3, 0)), 10, 0, 1, 0, 0, 0, VT_ILL, 0, 0);
        add_row(enc_vli(2, 5, vt(0, 0)), 9, 0, 1, 9, 0, 9, vt(0, 0), 0, 0);
        add_row(enc_vli(2, 5, vt(0, 4)), 9, 0, 1, 0, 0, 0, VT_ILL, 0, 0);
        add_row(enc_vli(2, 5, vt(0, 0)), 9, 0, 1, 9, 0, 9, vt(0, 0), 0, 0);
        add_row(enc_vli(2, 5, 11'h040), 9, 0, 1, 0, 0, 0, VT_ILL, 0, 0);
        add_row(enc_vl(2, 5, 6), 6, 32'h11, 1, 6, 0, 6, vt(2, 1), 0, 0);
        // vstart keeps the low bits of the written value
        add_row(enc_csr(3'b001, 7, 5, vcfg_op_pkg::VSTART), 32'h125, 0, 1, 0, 0,
                6, vt(2, 1), 8'h25, 0);
        add_row(enc_csr(3'b010, 7, 0, vcfg_op_pkg::VSTART), 0, 0, 1, 32'h25, 0,
                6, vt(2, 1), 8'h25, 0);
        add_row(enc_ivli(3, 4, vt(0, 0)), 0, 0, 1, 4, 0, 4, vt(0, 0), 0, 0);
        add_row(enc_csr(3'b010, 7, 0, vcfg_op_pkg::VSTART), 0, 0, 1, 0, 0, 4, vt(0, 0), 0, 0);
        add_row(enc_csr(3'b010, 8, 0, vcfg_op_pkg::VLENB), 0, 0, 1, 16, 0, 4, vt(0, 0), 0, 0);
        // rejected: write to vl, unknown csr, foreign opcode
        add_row(enc_csr(3'b001, 8, 5, vcfg_op_pkg::VL), 3, 0, 0, 0, 1, 4, vt(0, 0), 0, 0);
        add_row(enc_csr(3'b010, 1, 0, 12'h123), 0, 0, 0, 0, 1, 4, vt(0, 0), 0, 0);
        add_row(32'h0000_0013, 0, 0, 0, 0, 1, 4, vt(0, 0), 0, 0);
        add_row(enc_csr(3'b010, 1, 0, vcfg_op_pkg::VTYPE), 0, 0, 1, 0, 0, 4, vt(0, 0), 0, 0);
        // back to back pairs, the read sees the vl just set
        add_row(enc_vli(2, 5, vt(1, 0)), 50, 0, 1, 8, 0, 8, vt(1, 0), 0, 1);
        add_row(enc_csr(3'b010, 9, 0, vcfg_op_pkg::VL), 0, 0, 1, 8, 0, 8, vt(1, 0), 0, 0);
        add_row(enc_ivli(0, 3, vt(0, 0)), 0, 0, 0, 0, 0, 3, vt(0, 0), 0, 1);
        add_row(enc_csr(3'b010, 9, 0, vcfg_op_pkg::VL), 0, 0, 1, 3, 0, 3, vt(0, 0), 0, 0);
    endtask

    initial begin
        int          i;
        int          k;
        logic [31:0] avl;
        logic [2:0]  sew;
        logic [2:0]  lmul;

        nRST       = 1'b0;
        lfsr_state = 16'd59623;
        drive_idle();
        fill_table();
        if (n_rows != N_ROWS) begin
            $display("the stimulus table holds %0d rows instead of %0d", n_rows, N_ROWS);
            $display("STATUS: FAIL");
            $fatal(1, "table size");
        end

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        i = 0;
        while (i < N_ROWS) begin
            if (rows[i].chain && (i + 1 < N_ROWS)) begin
                run_pair(rows[i], rows[i + 1]);
                i += 2;
            end else begin
                run_single(rows[i]);
                i += 1;
            end
        end

        // random vsetvli, avl wide enough to pass vlmax at times
        for (k = 0; k < N_RAND; k++) begin
            avl  = rand_bits(8);
            sew  = rand_bits(2);
            lmul = rand_bits(3);
            run_single(ref_vsetvli(enc_vli(6, 5, vt(sew, lmul)), avl));
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- sim.f
+incdir+logic
logic/vcfg_types_pkg.sv
logic/vcfg_op_pkg.sv
logic/vcfg_req_if.sv
logic/vcfg_wb_if.sv
logic/vcfg_decode.sv
logic/vector_csr_file.sv
logic/vcfg_result.sv
logic/vcfg_unit.sv
verif/vcfg_unit_tb.sv

//--- Bender.yml
package:
  name: vcfg_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/vcfg_types_pkg.sv
      - logic/vcfg_op_pkg.sv
      - logic/vcfg_req_if.sv
      - logic/vcfg_wb_if.sv
      - logic/vcfg_decode.sv
      - logic/vector_csr_file.sv
      - logic/vcfg_result.sv
      - logic/vcfg_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/vcfg_unit_tb.sv
